//--- logic/numbat_pkg.sv
//######################################
// Numbat material evaluator definitions
//######################################

`default_nettype none

package numbat_pkg;

   localparam int PIECE_WIDTH = 4;
   localparam int BOARD_WIDTH = 64 * PIECE_WIDTH;   // 64 squares

   typedef enum logic [2:0] {
      EMPTY  = 3'd0,
      PAWN   = 3'd1,
      KNIGHT = 3'd2,
      BISHOP = 3'd3,
      ROOK   = 3'd4,
      QUEEN  = 3'd5,
      KING   = 3'd6
   } piece_kind_e;

   // Same four bits, either a table index or a side plus a kind
   typedef union packed {
      logic [PIECE_WIDTH-1:0] code;
      struct packed {
         logic        black;                         // Set for black pieces
         piece_kind_e kind;
      } fields;
   } square_t;

   localparam logic [PIECE_WIDTH-1:0] WHITE_PAWN = {1'b0, PAWN};
   localparam logic [PIECE_WIDTH-1:0] WHITE_KNIT = {1'b0, KNIGHT};
   localparam logic [PIECE_WIDTH-1:0] WHITE_BISH = {1'b0, BISHOP};
   localparam logic [PIECE_WIDTH-1:0] WHITE_ROOK = {1'b0, ROOK};
   localparam logic [PIECE_WIDTH-1:0] WHITE_QUEN = {1'b0, QUEEN};
   localparam logic [PIECE_WIDTH-1:0] WHITE_KING = {1'b0, KING};
   localparam logic [PIECE_WIDTH-1:0] BLACK_PAWN = {1'b1, PAWN};
   localparam logic [PIECE_WIDTH-1:0] BLACK_KNIT = {1'b1, KNIGHT};
   localparam logic [PIECE_WIDTH-1:0] BLACK_BISH = {1'b1, BISHOP};
   localparam logic [PIECE_WIDTH-1:0] BLACK_ROOK = {1'b1, ROOK};
   localparam logic [PIECE_WIDTH-1:0] BLACK_QUEN = {1'b1, QUEEN};
   localparam logic [PIECE_WIDTH-1:0] BLACK_KING = {1'b1, KING};

   localparam logic signed [15:0] PAWN_VALUE   = 16'sd100;
   localparam logic signed [15:0] KNIGHT_VALUE = 16'sd305;
   localparam logic signed [15:0] BISHOP_VALUE = 16'sd305;
   localparam logic signed [15:0] ROOK_VALUE   = 16'sd490;
   localparam logic signed [15:0] QUEEN_VALUE  = 16'sd1000;
   localparam logic signed [15:0] KING_VALUE   = 16'sd0;    // Kings never traded

   // Phase points, pawns and kings score none
   localparam int KNIGHT_PHASE = 3;
   localparam int BISHOP_PHASE = 3;
   localparam int ROOK_PHASE   = 5;
   localparam int QUEEN_PHASE  = 9;

   localparam int MOVE_BONUS_MG = 8;
   localparam int MOVE_BONUS_EG = 5;
   localparam int BAD_TRADE     = 90;

   localparam int EVAL_LATENCY  = 8;
   localparam int PHASE_LATENCY = 4;

   // Signed material of one square, black counts negative
   function automatic logic signed [15:0] piece_value(logic [PIECE_WIDTH-1:0] code);
      case (code)
         WHITE_PAWN: return PAWN_VALUE;
         WHITE_KNIT: return KNIGHT_VALUE;
         WHITE_BISH: return BISHOP_VALUE;
         WHITE_ROOK: return ROOK_VALUE;
         WHITE_QUEN: return QUEEN_VALUE;
         WHITE_KING: return KING_VALUE;
         BLACK_PAWN: return -PAWN_VALUE;
         BLACK_KNIT: return -KNIGHT_VALUE;
         BLACK_BISH: return -BISHOP_VALUE;
         BLACK_ROOK: return -ROOK_VALUE;
         BLACK_QUEN: return -QUEEN_VALUE;
         BLACK_KING: return -KING_VALUE;
         default:    return '0;
      endcase
   endfunction

   function automatic logic [3:0] phase_points(piece_kind_e kind);
      case (kind)
         KNIGHT:  return 4'(KNIGHT_PHASE);
         BISHOP:  return 4'(BISHOP_PHASE);
         ROOK:    return 4'(ROOK_PHASE);
         QUEEN:   return 4'(QUEEN_PHASE);
         default: return 4'd0;
      endcase
   endfunction

endpackage

`default_nettype wire

//--- logic/popcount.sv
//######################################
// Registered 64-bit population count
//######################################

`default_nettype none

module popcount (
   input  logic        clk,
   input  logic [63:0] x,
   output logic [6:0]  population
);

   logic [2:0] sum4  [16];   // Up to 4
   logic [4:0] sum16 [4];    // Up to 16
   logic [6:0] total;

   always_comb
   begin
      for (int i = 0; i < 16; i++)
      begin
         sum4[i] = 3'(x[4*i]) + 3'(x[4*i+1]) + 3'(x[4*i+2]) + 3'(x[4*i+3]);
      end
      for (int j = 0; j < 4; j++)
      begin
         sum16[j] = 5'(sum4[4*j]) + 5'(sum4[4*j+1]) + 5'(sum4[4*j+2]) + 5'(sum4[4*j+3]);
      end
      // Full board of 64 needs the seventh bit
      total = 7'(sum16[0]) + 7'(sum16[1]) + 7'(sum16[2]) + 7'(sum16[3]);
   end

   always_ff @(posedge clk)
   begin
      population <= total;
   end

endmodule

`default_nettype wire

//--- logic/phase_count.sv
//######################################
// Per-side phase point totals
//######################################

`default_nettype none

module phase_count #(
   parameter int P_VAL_WIDTH = 8
) (
   input  logic                                  clk,
   input  logic [numbat_pkg::BOARD_WIDTH-1:0]    board,
   output logic signed [P_VAL_WIDTH-1:0]         totp_white,
   output logic signed [P_VAL_WIDTH-1:0]         totp_black
);

   numbat_pkg::square_t squares [64];

   logic [3:0] white_pts_t1 [64];
   logic [3:0] black_pts_t1 [64];
   logic [5:0] white_grp_t2 [16];   // Groups of four squares
   logic [5:0] black_grp_t2 [16];
   logic [7:0] white_grp_t3 [4];    // Groups of sixteen
   logic [7:0] black_grp_t3 [4];

   always_comb
   begin
      for (int i = 0; i < 64; i++)
      begin
         squares[i] = board[i*numbat_pkg::PIECE_WIDTH +: numbat_pkg::PIECE_WIDTH];
      end
   end

   // Points go to the side named by the black bit
   always_ff @(posedge clk)
   begin
      for (int i = 0; i < 64; i++)
      begin
         white_pts_t1[i] <= squares[i].fields.black ? 4'd0 :
                            numbat_pkg::phase_points(squares[i].fields.kind);
         black_pts_t1[i] <= squares[i].fields.black ?
                            numbat_pkg::phase_points(squares[i].fields.kind) : 4'd0;
      end
   end

   always_ff @(posedge clk)
   begin
      for (int i = 0; i < 16; i++)
      begin
         white_grp_t2[i] <= 6'(white_pts_t1[4*i])   + 6'(white_pts_t1[4*i+1]) +
                            6'(white_pts_t1[4*i+2]) + 6'(white_pts_t1[4*i+3]);
         black_grp_t2[i] <= 6'(black_pts_t1[4*i])   + 6'(black_pts_t1[4*i+1]) +
                            6'(black_pts_t1[4*i+2]) + 6'(black_pts_t1[4*i+3]);
      end
      for (int j = 0; j < 4; j++)
      begin
         white_grp_t3[j] <= 8'(white_grp_t2[4*j])   + 8'(white_grp_t2[4*j+1]) +
                            8'(white_grp_t2[4*j+2]) + 8'(white_grp_t2[4*j+3]);
         black_grp_t3[j] <= 8'(black_grp_t2[4*j])   + 8'(black_grp_t2[4*j+1]) +
                            8'(black_grp_t2[4*j+2]) + 8'(black_grp_t2[4*j+3]);
      end
      // Legal positions stay far below the range of P_VAL_WIDTH
      totp_white <= P_VAL_WIDTH'(10'(white_grp_t3[0]) + 10'(white_grp_t3[1]) +
                                 10'(white_grp_t3[2]) + 10'(white_grp_t3[3]));
      totp_black <= P_VAL_WIDTH'(10'(black_grp_t3[0]) + 10'(black_grp_t3[1]) +
                                 10'(black_grp_t3[2]) + 10'(black_grp_t3[3]));
   end

endmodule

`default_nettype wire

//--- logic/evaluate_material.sv
//######################################
// Material score with bad-trade term
//######################################

`default_nettype none

module evaluate_material #(
   parameter int EVAL_WIDTH  = 16,
   parameter int P_VAL_WIDTH = 8
) (
   input  logic                                  clk,
   input  logic                                  arst_n,
   input  logic                                  board_valid,
   input  logic [numbat_pkg::BOARD_WIDTH-1:0]    board,
   input  logic                                  white_to_move,
   input  logic signed [P_VAL_WIDTH-1:0]         totp_white,   // Arrives at t4
   input  logic signed [P_VAL_WIDTH-1:0]         totp_black,
   output logic                                  eval_valid,
   output logic signed [EVAL_WIDTH-1:0]          eval_mg,
   output logic signed [EVAL_WIDTH-1:0]          eval_eg
);

   localparam logic signed [EVAL_WIDTH-1:0] BONUS_MG = EVAL_WIDTH'(numbat_pkg::MOVE_BONUS_MG);
   localparam logic signed [EVAL_WIDTH-1:0] BONUS_EG = EVAL_WIDTH'(numbat_pkg::MOVE_BONUS_EG);
   localparam logic signed [EVAL_WIDTH-1:0] TRADE_CORR = EVAL_WIDTH'(numbat_pkg::BAD_TRADE);

   numbat_pkg::square_t squares [64];

   logic [numbat_pkg::EVAL_LATENCY-1:0]  valid_sr;
   logic [numbat_pkg::PHASE_LATENCY-1:0] wtm_sr;      // Side to move, t1..t4

   logic signed [EVAL_WIDTH-1:0] material_t1 [64];
   logic signed [EVAL_WIDTH-1:0] sum_t2 [16];
   logic signed [EVAL_WIDTH-1:0] sum_t3 [4];
   logic signed [EVAL_WIDTH-1:0] sum_t4;
   logic signed [EVAL_WIDTH-1:0] sum_mg_t5, sum_mg_t6, sum_mg_t7;
   logic signed [EVAL_WIDTH-1:0] sum_eg_t5, sum_eg_t6, sum_eg_t7;

   logic [63:0] quen_white_t1, quen_black_t1;
   logic [63:0] rook_white_t1, rook_black_t1;
   logic [63:0] minor_white_t1, minor_black_t1;
   logic [6:0]  quen_white_cnt_t2, quen_black_cnt_t2;
   logic [6:0]  rook_white_cnt_t2, rook_black_cnt_t2;
   logic [6:0]  minor_white_cnt_t2, minor_black_cnt_t2;

   logic signed [EVAL_WIDTH-1:0]  majors_t3;
   logic signed [EVAL_WIDTH-1:0]  minors_t3;
   logic                          uneven_t4, uneven_t5;
   logic signed [P_VAL_WIDTH:0]   tot_diff_t5;        // One bit more than the totals
   logic signed [EVAL_WIDTH-1:0]  corr_t6, corr_t7;

   function automatic logic is_piece(numbat_pkg::square_t sq,
                                     numbat_pkg::piece_kind_e kind, logic black);
      return sq.fields.kind == kind && sq.fields.black == black;
   endfunction

   function automatic logic signed [8:0] cnt_diff(logic [6:0] a, logic [6:0] b);
      return $signed({2'b00, a}) - $signed({2'b00, b});
   endfunction

   always_comb
   begin
      for (int i = 0; i < 64; i++)
      begin
         squares[i] = board[i*numbat_pkg::PIECE_WIDTH +: numbat_pkg::PIECE_WIDTH];
      end
   end

   // Valid strobe is the only state that sees reset
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         valid_sr <= '0;
      else
         valid_sr <= {valid_sr[numbat_pkg::EVAL_LATENCY-2:0], board_valid};
   end

   assign eval_valid = valid_sr[numbat_pkg::EVAL_LATENCY-1];

   always_ff @(posedge clk)
   begin
      wtm_sr <= {wtm_sr[numbat_pkg::PHASE_LATENCY-2:0], white_to_move};
   end

   // Occupancy masks for the balance check
   always_ff @(posedge clk)
   begin
      for (int i = 0; i < 64; i++)
      begin
         quen_white_t1[i]  <= is_piece(squares[i], numbat_pkg::QUEEN, 1'b0);
         quen_black_t1[i]  <= is_piece(squares[i], numbat_pkg::QUEEN, 1'b1);
         rook_white_t1[i]  <= is_piece(squares[i], numbat_pkg::ROOK, 1'b0);
         rook_black_t1[i]  <= is_piece(squares[i], numbat_pkg::ROOK, 1'b1);
         minor_white_t1[i] <= is_piece(squares[i], numbat_pkg::KNIGHT, 1'b0) ||
                              is_piece(squares[i], numbat_pkg::BISHOP, 1'b0);
         minor_black_t1[i] <= is_piece(squares[i], numbat_pkg::KNIGHT, 1'b1) ||
                              is_piece(squares[i], numbat_pkg::BISHOP, 1'b1);
      end
   end

   popcount quen_white  (.clk(clk), .x(quen_white_t1),  .population(quen_white_cnt_t2));
   popcount quen_black  (.clk(clk), .x(quen_black_t1),  .population(quen_black_cnt_t2));
   popcount rook_white  (.clk(clk), .x(rook_white_t1),  .population(rook_white_cnt_t2));
   popcount rook_black  (.clk(clk), .x(rook_black_t1),  .population(rook_black_cnt_t2));
   popcount minor_white (.clk(clk), .x(minor_white_t1), .population(minor_white_cnt_t2));
   popcount minor_black (.clk(clk), .x(minor_black_t1), .population(minor_black_cnt_t2));

   always_ff @(posedge clk)
   begin
      // Queen weighted at twice its phase points
      majors_t3 <= EVAL_WIDTH'(
         numbat_pkg::ROOK_PHASE * cnt_diff(rook_white_cnt_t2, rook_black_cnt_t2) +
         2 * numbat_pkg::QUEEN_PHASE * cnt_diff(quen_white_cnt_t2, quen_black_cnt_t2));
      minors_t3 <= EVAL_WIDTH'(
         numbat_pkg::KNIGHT_PHASE * cnt_diff(minor_white_cnt_t2, minor_black_cnt_t2));

      uneven_t4 <= majors_t3 != 0 || minors_t3 != 0;
      uneven_t5 <= uneven_t4;
      tot_diff_t5 <= (P_VAL_WIDTH+1)'(totp_white) - (P_VAL_WIDTH+1)'(totp_black);

      corr_t6 <= '0;
      if (uneven_t5 && tot_diff_t5 != 0 && tot_diff_t5 != 2 && tot_diff_t5 != -2)
         corr_t6 <= (tot_diff_t5 < 0) ? -TRADE_CORR : TRADE_CORR;
      corr_t7 <= corr_t6;
   end

   // Value tree, four squares per node
   always_ff @(posedge clk)
   begin
      for (int i = 0; i < 64; i++)
      begin
         material_t1[i] <= EVAL_WIDTH'(numbat_pkg::piece_value(squares[i].code));
      end
      for (int i = 0; i < 16; i++)
      begin
         sum_t2[i] <= material_t1[4*i] + material_t1[4*i+1] +
                      material_t1[4*i+2] + material_t1[4*i+3];
      end
      for (int i = 0; i < 4; i++)
      begin
         sum_t3[i] <= sum_t2[4*i] + sum_t2[4*i+1] + sum_t2[4*i+2] + sum_t2[4*i+3];
      end
      sum_t4 <= sum_t3[0] + sum_t3[1] + sum_t3[2] + sum_t3[3];

      sum_mg_t5 <= sum_t4 + (wtm_sr[numbat_pkg::PHASE_LATENCY-1] ? BONUS_MG : -BONUS_MG);
      sum_eg_t5 <= sum_t4 + (wtm_sr[numbat_pkg::PHASE_LATENCY-1] ? BONUS_EG : -BONUS_EG);
      sum_mg_t6 <= sum_mg_t5;
      sum_eg_t6 <= sum_eg_t5;
      sum_mg_t7 <= sum_mg_t6;
      sum_eg_t7 <= sum_eg_t6;

      eval_mg <= sum_mg_t7 + corr_t7;   // t8
      eval_eg <= sum_eg_t7 + corr_t7;
   end

endmodule

`default_nettype wire

//--- logic/numbat_eval.sv
//######################################
// Numbat material evaluator top
//######################################

`default_nettype none

module numbat_eval #(
   parameter int EVAL_WIDTH  = 16,
   parameter int P_VAL_WIDTH = 8
) (
   input  logic                                  clk,
   input  logic                                  arst_n,
   input  logic                                  board_valid,
   input  logic [numbat_pkg::BOARD_WIDTH-1:0]    board,
   input  logic                                  white_to_move,
   output logic                                  eval_valid,
   output logic signed [EVAL_WIDTH-1:0]          eval_mg,
   output logic signed [EVAL_WIDTH-1:0]          eval_eg
);

   // Phase totals, valid four cycles after the board
   logic signed [P_VAL_WIDTH-1:0] totp_white;
   logic signed [P_VAL_WIDTH-1:0] totp_black;

   phase_count #(
      .P_VAL_WIDTH (P_VAL_WIDTH)
   ) phase_count_i (
      .clk        (clk),
      .board      (board),
      .totp_white (totp_white),
      .totp_black (totp_black)
   );

   evaluate_material #(
      .EVAL_WIDTH  (EVAL_WIDTH),
      .P_VAL_WIDTH (P_VAL_WIDTH)
   ) evaluate_material_i (
      .clk           (clk),
      .arst_n        (arst_n),
      .board_valid   (board_valid),
      .board         (board),
      .white_to_move (white_to_move),
      .totp_white    (totp_white),
      .totp_black    (totp_black),
      .eval_valid    (eval_valid),
      .eval_mg       (eval_mg),
      .eval_eg       (eval_eg)
   );

endmodule

`default_nettype wire

//--- verification/numbat_eval_properties.sv
//########################################
// Evaluator timing properties
//########################################

`default_nettype none

module numbat_eval_properties #(
   parameter int P_VAL_WIDTH = 8
) (
   input logic                          clk,
   input logic                          arst_n,
   input logic                          board_valid,
   input logic                          eval_valid,
   input logic signed [P_VAL_WIDTH-1:0] totp_white,
   input logic signed [P_VAL_WIDTH-1:0] totp_black
);

   // Queen, two rooks, four minors, eight promoted queens
   localparam int MAX_PHASE = 9*1 + 5*2 + 3*4 + 8*9;

   int failures = 0;

   valid_latency: assert property (@(posedge clk) disable iff (!arst_n)
      board_valid |-> ##(numbat_pkg::EVAL_LATENCY) eval_valid)
   else
   begin
      failures++;
      $error("eval_valid missing %0d cycles after board_valid", numbat_pkg::EVAL_LATENCY);
   end

   valid_in_reset: assert property (@(posedge clk)
      !arst_n |-> !eval_valid ##1 !eval_valid)
   else
   begin
      failures++;
      $error("eval_valid high during or just after reset");
   end

   // Totals line up with the board four edges later
   phase_range: assert property (@(posedge clk) disable iff (!arst_n)
      $past(board_valid, numbat_pkg::PHASE_LATENCY) |->
         totp_white >= 0 && totp_white <= MAX_PHASE &&
         totp_black >= 0 && totp_black <= MAX_PHASE)
   else
   begin
      failures++;
      $error("Phase total out of range, white %0d black %0d", totp_white, totp_black);
   end

endmodule

bind evaluate_material numbat_eval_properties #(
   .P_VAL_WIDTH (P_VAL_WIDTH)
) properties_i (
   .clk         (clk),
   .arst_n      (arst_n),
   .board_valid (board_valid),
   .eval_valid  (eval_valid),
   .totp_white  (totp_white),
   .totp_black  (totp_black)
);

`default_nettype wire

//--- verification/numbat_eval_tb.sv
//########################################
// Numbat evaluator testbench
//########################################

`default_nettype none

module numbat_eval_tb;

   localparam int EVAL_WIDTH  = 16;
   localparam int P_VAL_WIDTH = 8;
   localparam int BW          = numbat_pkg::BOARD_WIDTH;
   // Tests need roughly 700 cycles
   localparam int TIMEOUT_CYCLES = 4000;

   typedef struct {
      logic signed [EVAL_WIDTH-1:0] mg;
      logic signed [EVAL_WIDTH-1:0] eg;
      int                           due;   // Monitor cycle of the result
   } result_t;

   logic                         clk = 1'b0;
   logic                         arst_n;
   logic                         board_valid;
   logic [BW-1:0]                board;
   logic                         white_to_move;
   logic                         eval_valid;
   logic signed [EVAL_WIDTH-1:0] eval_mg;
   logic signed [EVAL_WIDTH-1:0] eval_eg;

   result_t expected_q [$];
   int      cycle = 0;
   string   test_name = "setup";

   numbat_eval #(
      .EVAL_WIDTH  (EVAL_WIDTH),
      .P_VAL_WIDTH (P_VAL_WIDTH)
   ) numbat_eval_i (
      .clk           (clk),
      .arst_n        (arst_n),
      .board_valid   (board_valid),
      .board         (board),
      .white_to_move (white_to_move),
      .eval_valid    (eval_valid),
      .eval_mg       (eval_mg),
      .eval_eg       (eval_eg)
   );

   initial
   begin
      forever #20 clk = ~clk;
   end

   task automatic stop_on_error(input string reason);
      $display("%s", reason);
      $display("TEST FAILED");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   task automatic compare_eval(input string what, input logic signed [EVAL_WIDTH-1:0] expected,
                               input logic signed [EVAL_WIDTH-1:0] actual);
      if (actual !== expected)
         stop_on_error($sformatf("Error in %s, %s: expected %0d, actual %0d",
                                 test_name, what, expected, actual));
   endtask

   task automatic compare_valid(input logic expected, input logic actual);
      if (actual !== expected)
         stop_on_error($sformatf("Error in %s, eval_valid: expected %b, actual %b",
                                 test_name, expected, actual));
   endtask

   // Falling edge, outputs settled
   always @(negedge clk)
   begin : monitor
      logic    due_now;
      result_t front;
      cycle++;
      if (cycle >= TIMEOUT_CYCLES)
         stop_on_error("timeout: results did not arrive");
      due_now = expected_q.size() != 0 && expected_q[0].due == cycle;
      compare_valid(due_now, eval_valid);
      if (due_now)
      begin
         front = expected_q.pop_front();
         compare_eval("eval_mg", front.mg, eval_mg);
         compare_eval("eval_eg", front.eg, eval_eg);
      end
   end

   function automatic int piece_worth(logic [2:0] kind);
      case (kind)
         numbat_pkg::PAWN:   return numbat_pkg::PAWN_VALUE;
         numbat_pkg::KNIGHT: return numbat_pkg::KNIGHT_VALUE;
         numbat_pkg::BISHOP: return numbat_pkg::BISHOP_VALUE;
         numbat_pkg::ROOK:   return numbat_pkg::ROOK_VALUE;
         numbat_pkg::QUEEN:  return numbat_pkg::QUEEN_VALUE;
         default:            return 0;   // Empty and king
      endcase
   endfunction

   function automatic int phase_of(logic [2:0] kind);
      case (kind)
         numbat_pkg::KNIGHT: return 3;
         numbat_pkg::BISHOP: return 3;
         numbat_pkg::ROOK:   return 5;
         numbat_pkg::QUEEN:  return 9;
         default:            return 0;
      endcase
   endfunction

   task automatic reference_eval(input logic [BW-1:0] b, input logic wtm,
                                 output logic signed [EVAL_WIDTH-1:0] mg,
                                 output logic signed [EVAL_WIDTH-1:0] eg);
      int         sum, white_phase, black_phase, phase_diff, majors, minors, corr, side;
      logic [3:0] code;
      sum = 0;
      white_phase = 0;
      black_phase = 0;
      majors = 0;
      minors = 0;
      for (int sq = 0; sq < 64; sq++)
      begin
         code = b[sq*4 +: 4];
         side = code[3] ? -1 : 1;
         sum += side * piece_worth(code[2:0]);
         if (code[3])
            black_phase += phase_of(code[2:0]);
         else
            white_phase += phase_of(code[2:0]);
         if (code[2:0] == numbat_pkg::ROOK)
            majors += side * 5;
         if (code[2:0] == numbat_pkg::QUEEN)
            majors += side * 18;
         if (code[2:0] == numbat_pkg::KNIGHT || code[2:0] == numbat_pkg::BISHOP)
            minors += side * 3;
      end
      phase_diff = white_phase - black_phase;
      corr = 0;
      if ((majors != 0 || minors != 0) && phase_diff != 0 && phase_diff != 2 && phase_diff != -2)
         corr = (phase_diff > 0) ? numbat_pkg::BAD_TRADE : -numbat_pkg::BAD_TRADE;
      mg = sum + corr + (wtm ? numbat_pkg::MOVE_BONUS_MG : -numbat_pkg::MOVE_BONUS_MG);
      eg = sum + corr + (wtm ? numbat_pkg::MOVE_BONUS_EG : -numbat_pkg::MOVE_BONUS_EG);
   endtask

   task automatic send_expected(input logic [BW-1:0] b, input logic wtm,
                                input logic signed [EVAL_WIDTH-1:0] mg,
                                input logic signed [EVAL_WIDTH-1:0] eg);
      result_t entry;
      @(posedge clk);
      board_valid   <= 1'b1;
      board         <= b;
      white_to_move <= wtm;
      entry.mg = mg;
      entry.eg = eg;
      entry.due = cycle + numbat_pkg::EVAL_LATENCY + 1;   // Counter lags this edge by one
      expected_q.push_back(entry);
   endtask

   task automatic send_board(input logic [BW-1:0] b, input logic wtm);
      logic signed [EVAL_WIDTH-1:0] mg, eg;
      reference_eval(b, wtm, mg, eg);
      send_expected(b, wtm, mg, eg);
   endtask

   task automatic idle(input int n);
      repeat (n)
      begin
         @(posedge clk);
         board_valid <= 1'b0;
      end
   endtask

   task automatic drain();
      idle(1);
      while (expected_q.size() != 0)
         @(posedge clk);
      idle(2);
   endtask

   task automatic put_piece(inout logic [BW-1:0] b, input int sq, input logic [3:0] code);
      b[sq*4 +: 4] = code;
   endtask

   task automatic place_random(inout logic [BW-1:0] b, input logic [3:0] code, input int count);
      int sq;
      repeat (count)
      begin
         sq = $urandom_range(63, 0);
         while (b[sq*4 +: 4] != 4'd0)
            sq = $urandom_range(63, 0);
         b[sq*4 +: 4] = code;
      end
   endtask

   // Kingless, at most one queen and two of each other piece per side
   task automatic random_board(output logic [BW-1:0] b);
      logic side;
      b = '0;
      for (int s = 0; s < 2; s++)
      begin
         side = s[0];
         place_random(b, {side, numbat_pkg::PAWN}, $urandom_range(8, 0));
         place_random(b, {side, numbat_pkg::KNIGHT}, $urandom_range(2, 0));
         place_random(b, {side, numbat_pkg::BISHOP}, $urandom_range(2, 0));
         place_random(b, {side, numbat_pkg::ROOK}, $urandom_range(2, 0));
         place_random(b, {side, numbat_pkg::QUEEN}, $urandom_range(1, 0));
      end
   endtask

   function automatic logic [BW-1:0] start_position();
      numbat_pkg::piece_kind_e back [8];
      logic [BW-1:0]           b;
      back = '{numbat_pkg::ROOK, numbat_pkg::KNIGHT, numbat_pkg::BISHOP, numbat_pkg::QUEEN,
               numbat_pkg::KING, numbat_pkg::BISHOP, numbat_pkg::KNIGHT, numbat_pkg::ROOK};
      b = '0;
      for (int f = 0; f < 8; f++)
      begin
         b[f*4 +: 4] = {1'b0, back[f]};
         b[(8+f)*4 +: 4] = numbat_pkg::WHITE_PAWN;
         b[(48+f)*4 +: 4] = numbat_pkg::BLACK_PAWN;
         b[(56+f)*4 +: 4] = {1'b1, back[f]};
      end
      return b;
   endfunction

   task automatic test_reset_idle();
      test_name = "test_reset_idle";
      @(posedge clk);
      arst_n <= 1'b0;
      repeat (10) @(posedge clk);
      arst_n <= 1'b1;
      idle(20);   // Monitor expects eval_valid low throughout
   endtask

   task automatic test_empty_and_start();
      test_name = "test_empty_and_start";
      send_expected('0, 1'b1, 8, 5);
      send_expected('0, 1'b0, -8, -5);
      send_expected(start_position(), 1'b1, 8, 5);
      send_expected(start_position(), 1'b0, -8, -5);
      drain();
   endtask

   task automatic test_random_material();
      logic [BW-1:0] b;
      test_name = "test_random_material";
      repeat (200)
      begin
         random_board(b);
         send_board(b, 1'($urandom_range(1, 0)));
         idle($urandom_range(2, 0));
      end
      drain();
   endtask

   task automatic test_bad_trade();
      logic [BW-1:0] b;
      test_name = "test_bad_trade";
      b = '0;                                           // Knight against three pawns
      put_piece(b, 4, numbat_pkg::WHITE_KING);
      put_piece(b, 1, numbat_pkg::WHITE_KNIT);
      put_piece(b, 60, numbat_pkg::BLACK_KING);
      put_piece(b, 48, numbat_pkg::BLACK_PAWN);
      put_piece(b, 49, numbat_pkg::BLACK_PAWN);
      put_piece(b, 50, numbat_pkg::BLACK_PAWN);
      send_expected(b, 1'b1, 103, 100);
      b = '0;                                           // Black up a rook
      put_piece(b, 4, numbat_pkg::WHITE_KING);
      put_piece(b, 60, numbat_pkg::BLACK_KING);
      put_piece(b, 56, numbat_pkg::BLACK_ROOK);
      send_expected(b, 1'b0, -588, -585);
      b = '0;                                           // Rook against knight and pawns
      put_piece(b, 4, numbat_pkg::WHITE_KING);
      put_piece(b, 0, numbat_pkg::WHITE_ROOK);
      put_piece(b, 60, numbat_pkg::BLACK_KING);
      put_piece(b, 57, numbat_pkg::BLACK_KNIT);
      put_piece(b, 48, numbat_pkg::BLACK_PAWN);
      put_piece(b, 49, numbat_pkg::BLACK_PAWN);
      send_expected(b, 1'b1, -7, -10);
      b = '0;                                           // Three minors against a queen
      put_piece(b, 4, numbat_pkg::WHITE_KING);
      put_piece(b, 1, numbat_pkg::WHITE_KNIT);
      put_piece(b, 6, numbat_pkg::WHITE_KNIT);
      put_piece(b, 2, numbat_pkg::WHITE_BISH);
      put_piece(b, 60, numbat_pkg::BLACK_KING);
      put_piece(b, 59, numbat_pkg::BLACK_QUEN);
      send_expected(b, 1'b0, -93, -90);
      drain();
   endtask

   task automatic test_streaming();
      logic [BW-1:0] b;
      test_name = "test_streaming";
      repeat (64)
      begin
         random_board(b);
         send_board(b, 1'($urandom_range(1, 0)));
      end
      drain();
   endtask

   task automatic test_sparse_valid();
      logic [BW-1:0] b;
      test_name = "test_sparse_valid";
      repeat (12)
      begin
         random_board(b);
         send_board(b, 1'($urandom_range(1, 0)));
         idle($urandom_range(12, 1));
      end
      drain();
   endtask

   initial
   begin
      void'($urandom(32'hff1a));
      arst_n        = 1'b1;
      board_valid   = 1'b0;
      board         = '0;
      white_to_move = 1'b0;
      test_reset_idle();
      test_empty_and_start();
      test_random_material();
      test_bad_trade();
      test_streaming();
      test_sparse_valid();
      if (numbat_eval_i.evaluate_material_i.properties_i.failures != 0)
         stop_on_error("A bound property check failed during the run");
      else
      begin
         $display("TEST PASSED");
         $finish;
      end
   end

endmodule

`default_nettype wire

//--- numbat_eval.f
logic/numbat_pkg.sv
logic/popcount.sv
logic/phase_count.sv
logic/evaluate_material.sv
logic/numbat_eval.sv
verification/numbat_eval_properties.sv
verification/numbat_eval_tb.sv

//--- Bender.yml
package:
  name: numbat_eval

sources:
  - logic/numbat_pkg.sv
  - logic/popcount.sv
  - logic/phase_count.sv
  - logic/evaluate_material.sv
  - logic/numbat_eval.sv
  - target: test
    files:
      - verification/numbat_eval_properties.sv
      - verification/numbat_eval_tb.sv
